/* logic/frontend_pkg.sv */
package frontend_pkg;

   // Instruction and address word width
   localparam int WORD_W = 32;

   // One word: instruction, PC or redirect target
   typedef logic [WORD_W-1:0] word_t;

   // Instruction memory word-address width, 256 words
   localparam int IMEM_AW = 8;
   localparam int IMEM_DEPTH = 1 << IMEM_AW; // Words in the instruction RAM

   // Word address into the instruction RAM
   typedef logic [IMEM_AW-1:0] imem_addr_t;

   // Byte offset bits below the word address in a PC
   localparam int WORD_OFS = 2;

   // Sequential fetch increment, bytes
   localparam word_t PC_STEP = 32'd4;

   // sll $0 $0 0, shown for a flushed IF/ID entry
   localparam word_t NOP_INSTR = 32'h0000_0000;

   // Controller states
   // ST_RUN      normal fetching, a load beat may start a load
   // ST_LOAD     program load in progress, fetch frozen
   // ST_RESTART  one cycle clearing PC and IF/ID before running again
   typedef enum logic [1:0] {
      ST_RUN     = 2'd0,
      ST_LOAD    = 2'd1,
      ST_RESTART = 2'd2
   } ctrl_state_t;

endpackage

/* logic/imem_if.sv */
// Instruction memory ports
// Read side belongs to the fetch stage, write side to the loader
interface imem_if;

   logic                     rd_en;   // Read enable, same as IF/ID write enable
   frontend_pkg::imem_addr_t rd_addr; // Word address, PC / 4
   frontend_pkg::word_t      rd_data; // Registered read data

   logic                     wr_en;   // One word per accepted load beat
   frontend_pkg::imem_addr_t wr_addr;
   frontend_pkg::word_t      wr_data;

   // Fetch stage side
   modport fetch (
      output rd_en,
      output rd_addr,
      input  rd_data
   );

   // Program loader side
   modport loader (
      output wr_en,
      output wr_addr,
      output wr_data
   );

   // The RAM itself
   modport mem (
      input  rd_en,
      input  rd_addr,
      output rd_data,
      input  wr_en,
      input  wr_addr,
      input  wr_data
   );

endinterface

/* logic/fetch_ctl_if.sv */
// Fetch enables from the controller to the fetch stage
interface fetch_ctl_if;

   logic pc_we;    // PC update
   logic if_id_we; // IF/ID capture and memory read
   logic flush;    // Entry captured this edge is wrong path
   logic pc_clear; // Restart at address 0, IF/ID invalid

   // Controller side
   modport drive (
      output pc_we,
      output if_id_we,
      output flush,
      output pc_clear
   );

   // Fetch stage side
   modport recv (
      input pc_we,
      input if_id_we,
      input flush,
      input pc_clear
   );

endinterface

/* logic/instr_mem.sv */
// Single-port instruction RAM
// Word write from the loader, registered read for fetch
// Read and write never share a cycle, fetch is frozen during loads
module instr_mem (
   input logic i_clk,
   imem_if.mem imem
);

   // Storage, no reset of the contents
   frontend_pkg::word_t ram [frontend_pkg::IMEM_DEPTH];

   // Read data register
   frontend_pkg::word_t rd_q;

   // Loader write port
   always_ff @(posedge i_clk) begin
      if (imem.wr_en) begin
         ram[imem.wr_addr] <= imem.wr_data; // One word per beat
      end
   end

   // Fetch read port
   // Output holds while rd_en is low, so a stalled
   // IF/ID entry keeps showing the same instruction
   always_ff @(posedge i_clk) begin
      if (imem.rd_en) begin
         rd_q <= ram[imem.rd_addr];
      end
   end

   assign imem.rd_data = rd_q; // Straight from the register

endmodule

/* logic/fetch_stage.sv */
// Fetch stage
// PC register with next-PC select, IF/ID register, NOP on flushed entries
module fetch_stage (
   input  logic                i_clk,
   input  logic                i_rst,
   input  frontend_pkg::word_t i_brq_addr,   // Branch target
   input  frontend_pkg::word_t i_jmp_addr,   // Jump target
   input  logic                i_ctr_beq,    // Branch taken
   input  logic                i_ctr_jmp,    // Jump taken
   fetch_ctl_if.recv           ctl,
   imem_if.fetch               imem,
   output frontend_pkg::word_t o_if_id_pc,
   output frontend_pkg::word_t o_if_id_instr,
   output logic                o_if_id_valid
);

   frontend_pkg::word_t pc_q;      // Current fetch address
   frontend_pkg::word_t pc_step;   // Sequential successor
   frontend_pkg::word_t pc_next;   // Selected next PC
   frontend_pkg::word_t if_id_pc_q;
   logic                if_id_valid_q;

   assign pc_step = pc_q + frontend_pkg::PC_STEP;

   // Target select only
   // Whether the PC moves at all is decided by pc_we
   always_comb begin
      if (i_ctr_jmp) begin
         pc_next = i_jmp_addr;   // Jump beats branch
      end else if (i_ctr_beq) begin
         pc_next = i_brq_addr;
      end else begin
         pc_next = pc_step;
      end
   end

   // Program counter
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_q <= '0;
      end else if (ctl.pc_clear) begin
         pc_q <= '0;             // Restart after a load
      end else if (ctl.pc_we) begin
         pc_q <= pc_next;
      end
   end

   // IF/ID register
   // Captures PC + 4 alongside the word read on the same edge
   always_ff @(posedge i_clk) begin
      if (i_rst || ctl.pc_clear) begin
         if_id_pc_q    <= '0;
         if_id_valid_q <= 1'b0;
      end else if (ctl.if_id_we) begin
         if_id_pc_q    <= pc_step;
         if_id_valid_q <= !ctl.flush; // Wrong-path entry on redirect
      end
   end

   // Memory read, word address is PC / 4
   assign imem.rd_en   = ctl.if_id_we;
   assign imem.rd_addr =
      pc_q[frontend_pkg::WORD_OFS +: frontend_pkg::IMEM_AW];

   // Flushed or empty entry shows NOP
   assign o_if_id_instr = if_id_valid_q ? imem.rd_data : frontend_pkg::NOP_INSTR;
   assign o_if_id_pc    = if_id_pc_q;
   assign o_if_id_valid = if_id_valid_q;

endmodule

/* logic/fetch_ctrl.sv */
// Fetch controller
// Program load over valid/ready, restart at word 0,
// stall and redirect turned into fetch enables
module fetch_ctrl (
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  logic                     i_load_valid,
   input  logic                     i_load_last,  // Final word of the program
   input  frontend_pkg::imem_addr_t i_load_addr,
   input  frontend_pkg::word_t      i_load_data,
   output logic                     o_load_ready,
   input  logic                     i_stall,      // Decode stage hold
   input  logic                     i_ctr_beq,
   input  logic                     i_ctr_jmp,
   fetch_ctl_if.drive               ctl,
   imem_if.loader                   imem
);

   frontend_pkg::ctrl_state_t state_q;
   frontend_pkg::ctrl_state_t state_d;

   logic load_fire;  // Beat accepted this edge
   logic redirect;   // Branch or jump taken
   logic run_fetch;  // Fetch allowed this cycle
   logic fetch_go;   // Fetch actually advances

   // Only the restart cycle pushes back on the loader
   assign o_load_ready = (state_q != frontend_pkg::ST_RESTART);
   assign load_fire    = i_load_valid && o_load_ready;

   // State register
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q <= frontend_pkg::ST_RUN;
      end else begin
         state_q <= state_d;
      end
   end

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         frontend_pkg::ST_RUN: begin
            if (load_fire) begin
               // Single-word program goes straight to restart
               state_d = i_load_last ? frontend_pkg::ST_RESTART
                                     : frontend_pkg::ST_LOAD;
            end
         end
         frontend_pkg::ST_LOAD: begin
            if (load_fire && i_load_last) begin
               state_d = frontend_pkg::ST_RESTART;
            end
         end
         frontend_pkg::ST_RESTART: begin
            state_d = frontend_pkg::ST_RUN;   // One cycle only
         end
         default: begin
            state_d = frontend_pkg::ST_RUN;
         end
      endcase
   end

   // Load beats straight into the RAM write port
   assign imem.wr_en   = load_fire;
   assign imem.wr_addr = i_load_addr;
   assign imem.wr_data = i_load_data;

   // Fetch enables
   // A beat taken in ST_RUN already freezes fetch, so the RAM
   // never sees a read and a write together
   assign redirect  = i_ctr_beq || i_ctr_jmp;
   assign run_fetch = (state_q == frontend_pkg::ST_RUN) && !load_fire;
   assign fetch_go  = run_fetch && (redirect || !i_stall); // Redirect overrides stall

   assign ctl.pc_we    = fetch_go;
   assign ctl.if_id_we = fetch_go;
   assign ctl.flush    = run_fetch && redirect;  // Mark the wrong-path entry
   assign ctl.pc_clear = (state_q == frontend_pkg::ST_RESTART);

endmodule

/* logic/mips_frontend.sv */
// Instruction front end top
// Controller, fetch stage and instruction RAM joined by two interfaces
module mips_frontend (
   input  logic                     i_clk,
   input  logic                     i_rst,

   // Program load port
   input  logic                     i_load_valid,
   input  logic                     i_load_last,
   input  frontend_pkg::imem_addr_t i_load_addr,
   input  frontend_pkg::word_t      i_load_data,
   output logic                     o_load_ready,

   // Pipeline side
   input  logic                     i_stall,
   input  logic                     i_ctr_beq,
   input  frontend_pkg::word_t      i_brq_addr,
   input  logic                     i_ctr_jmp,
   input  frontend_pkg::word_t      i_jmp_addr,
   output frontend_pkg::word_t      o_if_id_pc,
   output frontend_pkg::word_t      o_if_id_instr,
   output logic                     o_if_id_valid
);

   imem_if      u_imem_if ();      // RAM read and write ports
   fetch_ctl_if u_fetch_ctl_if (); // Enables to the fetch stage

   // Load FSM and enable generation
   fetch_ctrl u_fetch_ctrl (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_load_valid (i_load_valid),
      .i_load_last  (i_load_last),
      .i_load_addr  (i_load_addr),
      .i_load_data  (i_load_data),
      .o_load_ready (o_load_ready),
      .i_stall      (i_stall),
      .i_ctr_beq    (i_ctr_beq),
      .i_ctr_jmp    (i_ctr_jmp),
      .ctl          (u_fetch_ctl_if.drive),
      .imem         (u_imem_if.loader)
   );

   // PC and IF/ID
   fetch_stage u_fetch_stage (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_brq_addr    (i_brq_addr),
      .i_jmp_addr    (i_jmp_addr),
      .i_ctr_beq     (i_ctr_beq),
      .i_ctr_jmp     (i_ctr_jmp),
      .ctl           (u_fetch_ctl_if.recv),
      .imem          (u_imem_if.fetch),
      .o_if_id_pc    (o_if_id_pc),
      .o_if_id_instr (o_if_id_instr),
      .o_if_id_valid (o_if_id_valid)
   );

   // Instruction RAM
   instr_mem u_instr_mem (
      .i_clk (i_clk),
      .imem  (u_imem_if.mem)
   );

endmodule

/* verif/frontend_tb.sv */
module frontend_tb;

   localparam int CLK_PERIOD      = 4;
   localparam int RST_CYCLES      = 8;
   localparam int LOAD1_WORDS     = 256;  // Fills the whole RAM
   localparam int LOAD2_WORDS     = 64;   // Reload of the low words
   localparam int RUN1_CYCLES     = 300;
   localparam int RUN2_CYCLES     = 200;
   localparam int DIRECTED_CYCLES = 8;    // Per run phase
   localparam int LOAD_BEATS      = LOAD1_WORDS + LOAD2_WORDS;
   localparam int READBACK_CYCLES = LOAD_BEATS - 2;  // Word 0 comes with each restart
   localparam int RUN_TOTAL       = RUN1_CYCLES + RUN2_CYCLES + 2 * DIRECTED_CYCLES
                                    + READBACK_CYCLES;
   localparam int WATCHDOG_TIME   = ((LOAD_BEATS + RUN_TOTAL) * 2 + 100) * CLK_PERIOD;

   // Model controller states
   localparam logic [1:0] M_RUN     = 2'd0;
   localparam logic [1:0] M_LOAD    = 2'd1;
   localparam logic [1:0] M_RESTART = 2'd2;

   logic                     i_clk;
   logic                     i_rst;
   logic                     i_load_valid;
   logic                     i_load_last;
   frontend_pkg::imem_addr_t i_load_addr;
   frontend_pkg::word_t      i_load_data;
   logic                     o_load_ready;
   logic                     i_stall;
   logic                     i_ctr_beq;
   frontend_pkg::word_t      i_brq_addr;
   logic                     i_ctr_jmp;
   frontend_pkg::word_t      i_jmp_addr;
   frontend_pkg::word_t      o_if_id_pc;
   frontend_pkg::word_t      o_if_id_instr;
   logic                     o_if_id_valid;

   // Reference model state
   frontend_pkg::word_t m_mem [1 << frontend_pkg::IMEM_AW];
   logic [1:0]          m_state;
   frontend_pkg::word_t m_pc;
   frontend_pkg::word_t m_ifid_pc;
   frontend_pkg::word_t m_rd;       // Word read on the last fetch
   logic                m_valid;
   logic                m_ready;
   logic                m_fire;
   logic                m_redirect;
   logic                chk_on;     // Set by the first restart
   frontend_pkg::word_t exp_instr;

   int err_pc;
   int err_instr;
   int err_valid;
   int err_ready;
   int err_other;

   initial i_clk = 1'b0;
   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   mips_frontend u_mips_frontend (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_load_valid  (i_load_valid),
      .i_load_last   (i_load_last),
      .i_load_addr   (i_load_addr),
      .i_load_data   (i_load_data),
      .o_load_ready  (o_load_ready),
      .i_stall       (i_stall),
      .i_ctr_beq     (i_ctr_beq),
      .i_brq_addr    (i_brq_addr),
      .i_ctr_jmp     (i_ctr_jmp),
      .i_jmp_addr    (i_jmp_addr),
      .o_if_id_pc    (o_if_id_pc),
      .o_if_id_instr (o_if_id_instr),
      .o_if_id_valid (o_if_id_valid)
   );

   assign m_ready    = (m_state != M_RESTART);  // Loader blocked only in restart
   assign m_fire     = i_load_valid && m_ready;
   assign m_redirect = i_ctr_beq || i_ctr_jmp;
   assign exp_instr  = m_valid ? m_rd : frontend_pkg::NOP_INSTR;

   // Reference model, stepped on the same edges as the DUT
   always @(posedge i_clk) begin
      if (i_rst) begin
         m_state   <= M_RUN;
         m_pc      <= '0;
         m_ifid_pc <= '0;
         m_valid   <= 1'b0;
         chk_on    <= 1'b0;
      end else begin
         if (m_fire) begin
            m_mem[i_load_addr] <= i_load_data;
         end
         case (m_state)
            M_RUN: begin
               if (m_fire) begin
                  m_state <= i_load_last ? M_RESTART : M_LOAD;  // Fetch frozen
               end else if (m_redirect || !i_stall) begin
                  m_rd      <= m_mem[m_pc[frontend_pkg::IMEM_AW+1:2]];  // PC / 4
                  m_ifid_pc <= m_pc + 32'd4;
                  m_valid   <= !m_redirect;  // Wrong path on redirect
                  if (i_ctr_jmp) begin
                     m_pc <= i_jmp_addr;
                  end else if (i_ctr_beq) begin
                     m_pc <= i_brq_addr;
                  end else begin
                     m_pc <= m_pc + 32'd4;
                  end
               end
            end
            M_LOAD: begin
               if (m_fire && i_load_last) begin
                  m_state <= M_RESTART;
               end
            end
            default: begin
               m_pc      <= '0;  // Restart at word 0
               m_ifid_pc <= '0;
               m_valid   <= 1'b0;
               m_state   <= M_RUN;
               chk_on    <= 1'b1;
            end
         endcase
      end
   end

   // IF/ID outputs against the model
   pc_match: assert property (@(posedge i_clk) (!i_rst && chk_on) |-> o_if_id_pc == m_ifid_pc)
      else begin
         err_pc++;
         $display("FAILED t=%0t o_if_id_pc expected %h actual %h",
                  $time, $sampled(m_ifid_pc), $sampled(o_if_id_pc));
      end

   instr_match: assert property (@(posedge i_clk)
         (!i_rst && chk_on) |-> o_if_id_instr == exp_instr)
      else begin
         err_instr++;
         $display("FAILED t=%0t o_if_id_instr expected %h actual %h",
                  $time, $sampled(exp_instr), $sampled(o_if_id_instr));
      end

   valid_match: assert property (@(posedge i_clk)
         (!i_rst && chk_on) |-> o_if_id_valid == m_valid)
      else begin
         err_valid++;
         $display("FAILED t=%0t o_if_id_valid expected %b actual %b",
                  $time, $sampled(m_valid), $sampled(o_if_id_valid));
      end

   // Ready low only in the restart cycle
   ready_match: assert property (@(posedge i_clk) !i_rst |-> o_load_ready == m_ready)
      else begin
         err_ready++;
         $display("FAILED t=%0t o_load_ready expected %b actual %b",
                  $time, $sampled(m_ready), $sampled(o_load_ready));
      end

   ready_one_cycle: assert property (@(posedge i_clk)
         (!i_rst && !o_load_ready) |=> o_load_ready)
      else begin
         err_ready++;
         $display("Load port stayed blocked for more than one cycle at time %0t", $time);
      end

   // State right after reset
   reset_valid: assert property (@(posedge i_clk) $fell(i_rst) |-> !o_if_id_valid)
      else begin
         err_valid++;
         $display("FAILED t=%0t o_if_id_valid expected 0 actual %b",
                  $time, $sampled(o_if_id_valid));
      end

   reset_ready: assert property (@(posedge i_clk) $fell(i_rst) |-> o_load_ready)
      else begin
         err_ready++;
         $display("FAILED t=%0t o_load_ready expected 1 actual %b",
                  $time, $sampled(o_load_ready));
      end

   // Plain stall holds everything
   stall_hold: assert property (@(posedge i_clk)
         (!i_rst && chk_on && m_state == M_RUN && !m_fire && i_stall && !m_redirect)
         |=> ($stable(o_if_id_pc) && $stable(o_if_id_instr) && $stable(o_if_id_valid)))
      else begin
         err_other++;
         $display("IF/ID outputs changed under a stall at time %0t", $time);
      end

   // Outputs frozen while a load is in progress
   load_freeze: assert property (@(posedge i_clk)
         (!i_rst && chk_on && m_state == M_LOAD)
         |=> ($stable(o_if_id_pc) && $stable(o_if_id_instr) && $stable(o_if_id_valid)))
      else begin
         err_other++;
         $display("IF/ID outputs changed during a program load at time %0t", $time);
      end

   // Entry captured on a redirect edge is flushed
   flush_valid: assert property (@(posedge i_clk)
         (!i_rst && chk_on && m_state == M_RUN && !m_fire && m_redirect) |=> !o_if_id_valid)
      else begin
         err_valid++;
         $display("FAILED t=%0t o_if_id_valid expected 0 actual %b",
                  $time, $sampled(o_if_id_valid));
      end

   flush_instr: assert property (@(posedge i_clk)
         (!i_rst && chk_on && m_state == M_RUN && !m_fire && m_redirect)
         |=> o_if_id_instr == frontend_pkg::NOP_INSTR)
      else begin
         err_instr++;
         $display("FAILED t=%0t o_if_id_instr expected %h actual %h",
                  $time, frontend_pkg::NOP_INSTR, $sampled(o_if_id_instr));
      end

   // Word 0 visible two edges after the last beat
   first_word: assert property (@(posedge i_clk)
         (!i_rst && i_load_valid && o_load_ready && i_load_last)
         |-> ##3 (o_if_id_valid && o_if_id_pc == 32'd4))
      else begin
         err_other++;
         $display("Word 0 did not follow the last load beat by two edges, time %0t", $time);
      end

   // Word-aligned target inside the RAM
   function automatic frontend_pkg::word_t random_target();
      return frontend_pkg::word_t'(($urandom % (1 << frontend_pkg::IMEM_AW)) * 4);
   endfunction

   // One pipeline cycle of stall and redirect inputs
   task automatic apply_cycle(input logic stall, input logic beq, input logic jmp);
      i_stall    = stall;
      i_ctr_beq  = beq;
      i_brq_addr = random_target();
      i_ctr_jmp  = jmp;
      i_jmp_addr = random_target();
      @(posedge i_clk);
      #1;
   endtask

   // Words 0 to n_words-1 with random gaps and random stall and redirect inputs
   task automatic load_program(input int n_words);
      bit accepted;
      for (int i = 0; i < n_words; i++) begin
         i_load_valid = 1'b0;
         i_stall      = ($urandom % 2) == 0;  // Fetch ignores these from the first beat on
         i_ctr_beq    = ($urandom % 4) == 0;
         i_brq_addr   = random_target();
         i_ctr_jmp    = ($urandom % 4) == 0;
         i_jmp_addr   = random_target();
         repeat ($urandom % 2) begin
            @(posedge i_clk);
            #1;
         end
         i_load_valid = 1'b1;
         i_load_addr  = frontend_pkg::imem_addr_t'(i);
         i_load_data  = $urandom;
         i_load_last  = (i == n_words - 1);
         do begin
            accepted = o_load_ready;  // Ready for the coming edge
            @(posedge i_clk);
            #1;
         end while (!accepted);
      end
      i_load_valid = 1'b0;
      i_load_last  = 1'b0;
      i_stall      = 1'b0;
      i_ctr_beq    = 1'b0;
      i_ctr_jmp    = 1'b0;
      repeat (2) begin  // Restart, then fetch of word 0
         @(posedge i_clk);
         #1;
      end
   endtask

   // Plain sequential fetch of words 1 to n_words-1 after a restart
   task automatic read_back(input int n_words);
      repeat (n_words - 1) begin
         apply_cycle(1'b0, 1'b0, 1'b0);
      end
   endtask

   // Fixed redirect and stall corners
   task automatic directed_cycles();
      apply_cycle(1'b0, 1'b1, 1'b1);  // Both taken, jump wins
      apply_cycle(1'b0, 1'b0, 1'b0);
      apply_cycle(1'b1, 1'b1, 1'b0);  // Branch under stall
      apply_cycle(1'b1, 1'b0, 1'b1);  // Jump under stall
      apply_cycle(1'b1, 1'b0, 1'b0);
      apply_cycle(1'b1, 1'b0, 1'b0);
      apply_cycle(1'b0, 1'b1, 1'b0);
      apply_cycle(1'b0, 1'b0, 1'b0);
   endtask

   task automatic random_cycles(input int n_cycles);
      repeat (n_cycles) begin
         apply_cycle(($urandom % 4) == 0, ($urandom % 8) == 0, ($urandom % 8) == 0);
      end
   endtask

   initial begin
      int total;
      void'($urandom(32'h64c4));
      err_pc       = 0;
      err_instr    = 0;
      err_valid    = 0;
      err_ready    = 0;
      err_other    = 0;
      i_rst        = 1'b1;
      i_load_valid = 1'b0;
      i_load_last  = 1'b0;
      i_load_addr  = '0;
      i_load_data  = '0;
      i_stall      = 1'b1;  // No fetch from the empty RAM
      i_ctr_beq    = 1'b0;
      i_brq_addr   = '0;
      i_ctr_jmp    = 1'b0;
      i_jmp_addr   = '0;
      repeat (RST_CYCLES) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      repeat (3) begin
         @(posedge i_clk);
         #1;
      end
      load_program(LOAD1_WORDS);
      read_back(LOAD1_WORDS);
      directed_cycles();
      random_cycles(RUN1_CYCLES);
      load_program(LOAD2_WORDS);  // Reload while running
      read_back(LOAD2_WORDS);
      directed_cycles();
      random_cycles(RUN2_CYCLES);
      repeat (4) begin
         @(posedge i_clk);
         #1;
      end
      total = err_pc + err_instr + err_valid + err_ready + err_other;
      $display("Errors: pc %0d, instr %0d, valid %0d, ready %0d, other %0d",
               err_pc, err_instr, err_valid, err_ready, err_other);
      if (total == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_TIME);
      $display("Timeout: test still running after %0d time units", WATCHDOG_TIME);
      $display("Checks failed");
      $finish;
   end

endmodule

/* files.f */
logic/frontend_pkg.sv
logic/imem_if.sv
logic/fetch_ctl_if.sv
logic/instr_mem.sv
logic/fetch_stage.sv
logic/fetch_ctrl.sv
logic/mips_frontend.sv
verif/frontend_tb.sv

/* Bender.yml */
package:
  name: mips_frontend

sources:
  - files:
      - logic/frontend_pkg.sv
      - logic/imem_if.sv
      - logic/fetch_ctl_if.sv
      - logic/instr_mem.sv
      - logic/fetch_stage.sv
      - logic/fetch_ctrl.sv
      - logic/mips_frontend.sv
  - target: test
    files:
      - verif/frontend_tb.sv
